// File: list.f
+incdir+logic
logic/noc_pkg.sv
logic/noc_input_buffer.sv
logic/noc_output_port.sv
logic/noc_router.sv
logic/noc_mesh_3x3.sv
verification/noc_mesh_3x3_sva.sv
verification/tb_noc_mesh_3x3.sv

// File: Makefile
# Verilator build and run for the 3x3 mesh NoC.

VERILATOR ?= verilator
TOP ?= tb_noc_mesh_3x3
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= SIMULATION PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_noc_mesh_3x3.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module tb_noc_mesh_3x3;

	localparam int CLK_PERIOD = 8;
	localparam int VALID = `NOC_FLIT_WIDTH - 1;
	localparam int PAY_MSB = `NOC_PAYLOAD_WIDTH - 1;
	localparam int NUM_ROWS = 16;
	localparam int LIMIT_CYCLES = NUM_ROWS * 40 + 200;
	localparam logic [3:0] NONE = 4'hf; // Flit is dropped, nothing ejects.

	typedef struct packed {
		logic [3:0] src; // Injecting router, 0 or 8.
		noc_pkg::coord_t dest_x;
		noc_pkg::coord_t dest_y;
		logic [3:0] eject; // Router where the flit must come out.
		logic err; // Off-mesh destination.
	} row_t;

	localparam row_t STIM [NUM_ROWS] = '{
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0}, // Corner to corner.
		'{4'd8, 2'd0, 2'd0, 4'd0, 1'b0},
		'{4'd0, 2'd0, 2'd0, 4'd0, 1'b0}, // Own router.
		'{4'd8, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0}, // Ordered stream under random stops.
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd8, 2'd0, 2'd0, 4'd0, 1'b0},
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd8, 2'd0, 2'd0, 4'd0, 1'b0},
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd0, 2'd3, 2'd0, NONE, 1'b1}, // X outside the mesh.
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd8, 2'd1, 2'd3, NONE, 1'b1}, // Y outside the mesh.
		'{4'd8, 2'd0, 2'd0, 4'd0, 1'b0},
		'{4'd0, 2'd2, 2'd2, 4'd8, 1'b0},
		'{4'd8, 2'd0, 2'd0, 4'd0, 1'b0}
	};

	logic clk;
	logic arst_n;
	noc_pkg::flit_t injection_channel_0;
	logic injection_flow_ctrl_0;
	noc_pkg::flit_t ejection_channel_0;
	logic ejection_flow_ctrl_0;
	noc_pkg::flit_t injection_channel_8;
	logic injection_flow_ctrl_8;
	noc_pkg::flit_t ejection_channel_8;
	logic ejection_flow_ctrl_8;
	logic [`NOC_NUM_ROUTERS-1:0] rtr_error;

	logic stop_enable;
	int errors;
	int checks;
	int injected;
	int delivered;
	noc_pkg::payload_t exp_q [4][$]; // Ejection index times two plus source index.
	logic was_stopped [2];
	noc_pkg::flit_t held_flit [2];

	noc_mesh_3x3 u_noc_mesh_3x3 (
		.clk(clk),
		.arst_n(arst_n),
		.injection_channel_0(injection_channel_0),
		.injection_flow_ctrl_0(injection_flow_ctrl_0),
		.ejection_channel_0(ejection_channel_0),
		.ejection_flow_ctrl_0(ejection_flow_ctrl_0),
		.injection_channel_8(injection_channel_8),
		.injection_flow_ctrl_8(injection_flow_ctrl_8),
		.ejection_channel_8(ejection_channel_8),
		.ejection_flow_ctrl_8(ejection_flow_ctrl_8),
		.rtr_error(rtr_error)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic compare_value(input string what, input int got, input int want);
		checks++;
		if (got !== want)
			report_error($sformatf("%s is %0d, expected %0d", what, got, want));
	endtask

	function automatic int pending();
		return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
	endfunction

	// Holds the flit until the router's local input is free, then for one edge.
	task automatic inject(input logic [3:0] src, input noc_pkg::flit_t f);
		if (src == 4'd0) begin
			while (injection_flow_ctrl_0) begin
				@(posedge clk);
				#1;
			end
			injection_channel_0 = f;
			@(posedge clk);
			#1;
			injection_channel_0 = '0;
		end else begin
			while (injection_flow_ctrl_8) begin
				@(posedge clk);
				#1;
			end
			injection_channel_8 = f;
			@(posedge clk);
			#1;
			injection_channel_8 = '0;
		end
	endtask

	task automatic wait_error_bit(input int router);
		int n;
		n = 0;
		while (rtr_error[router] !== 1'b1 && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		checks++;
		if (rtr_error[router] !== 1'b1)
			report_error($sformatf("rtr_error[%0d] did not rise for an off-mesh flit", router));
	endtask

	// Called mid cycle. A transfer happens on the next edge if valid and not stopped.
	task automatic check_ejection(input int idx, input noc_pkg::flit_t f, input logic stopped);
		noc_pkg::payload_t pay;
		noc_pkg::payload_t want;
		logic [3:0] want_addr;
		int q;
		want_addr = (idx == 0) ? {2'd0, 2'd0} : {2'd2, 2'd2};
		if (was_stopped[idx] && f !== held_flit[idx])
			report_error($sformatf("router %0d ejection flit changed while stopped", idx * 8));
		if (f[VALID] && !stopped) begin
			pay = f[PAY_MSB:0];
			q = idx * 2 + int'(pay[PAY_MSB]);
			checks++;
			delivered++;
			if (f[VALID-1 -: 4] !== want_addr)
				report_error($sformatf("router %0d ejected address %h", idx * 8, f[VALID-1 -: 4]));
			if (exp_q[q].size() == 0) begin
				report_error($sformatf("router %0d ejected unexpected payload %h", idx * 8, pay));
			end else begin
				want = exp_q[q].pop_front();
				if (pay !== want)
					report_error($sformatf("router %0d payload %h, expected %h",
						idx * 8, pay, want));
			end
		end
		was_stopped[idx] = f[VALID] && stopped;
		held_flit[idx] = f;
	endtask

	// Random ejection stops, about one cycle in four.
	initial begin
		void'($urandom(32'hf480));
		ejection_flow_ctrl_0 = 1'b0;
		ejection_flow_ctrl_8 = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			ejection_flow_ctrl_0 = stop_enable && (($urandom % 4) == 0);
			ejection_flow_ctrl_8 = stop_enable && (($urandom % 4) == 0);
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (arst_n) begin
				check_ejection(0, ejection_channel_0, ejection_flow_ctrl_0);
				check_ejection(1, ejection_channel_8, ejection_flow_ctrl_8);
			end
		end
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles with %0d flits not delivered", LIMIT_CYCLES, pending());
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		noc_pkg::flit_t f;
		noc_pkg::payload_t pay;
		logic [`NOC_NUM_ROUTERS-1:0] err_mask;
		int q;
		arst_n = 1'b0;
		injection_channel_0 = '0;
		injection_channel_8 = '0;
		stop_enable = 1'b0;
		errors = 0;
		checks = 0;
		injected = 0;
		delivered = 0;
		err_mask = '0;
		was_stopped[0] = 1'b0;
		was_stopped[1] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		compare_value("ejection 0 valid", int'(ejection_channel_0[VALID]), 0);
		compare_value("ejection 8 valid", int'(ejection_channel_8[VALID]), 0);
		compare_value("injection 0 stop", int'(injection_flow_ctrl_0), 0);
		compare_value("injection 8 stop", int'(injection_flow_ctrl_8), 0);
		compare_value("rtr_error after reset", int'(rtr_error), 0);
		stop_enable = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			pay = {STIM[r].src == 4'd8, 29'(r)}; // Source flag, then sequence number.
			f = {1'b1, STIM[r].dest_x, STIM[r].dest_y, pay};
			if (STIM[r].eject != NONE) begin
				q = (STIM[r].eject == 4'd8 ? 2 : 0) + (STIM[r].src == 4'd8 ? 1 : 0);
				exp_q[q].push_back(pay);
				injected++;
			end
			inject(STIM[r].src, f);
			if (STIM[r].err) begin
				err_mask[STIM[r].src] = 1'b1;
				wait_error_bit(int'(STIM[r].src));
			end
		end

		while (pending() != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (20) @(posedge clk);
		#1;
		compare_value("rtr_error at end", int'(rtr_error), int'(err_mask));
		compare_value("delivered flits", delivered, injected);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/noc_mesh_3x3_sva.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module noc_mesh_3x3_sva (
	input wire logic clk,
	input wire logic arst_n,
	input wire noc_pkg::flit_t ejection_channel_0,
	input wire logic ejection_flow_ctrl_0,
	input wire noc_pkg::flit_t ejection_channel_8,
	input wire logic ejection_flow_ctrl_8,
	input wire logic injection_flow_ctrl_0,
	input wire logic injection_flow_ctrl_8,
	input wire logic [`NOC_NUM_ROUTERS-1:0] rtr_error
);

	localparam int VALID = `NOC_FLIT_WIDTH - 1;

	// A stopped ejection flit stays put.
	hold_ejection_0: assert property (@(posedge clk) disable iff (!arst_n)
		(ejection_channel_0[VALID] && ejection_flow_ctrl_0) |=> $stable(ejection_channel_0))
		else $error("Router 0 ejection flit changed while stopped");

	hold_ejection_8: assert property (@(posedge clk) disable iff (!arst_n)
		(ejection_channel_8[VALID] && ejection_flow_ctrl_8) |=> $stable(ejection_channel_8))
		else $error("Router 8 ejection flit changed while stopped");

	sticky_error: assert property (@(posedge clk) disable iff (!arst_n)
		(($past(rtr_error) & ~rtr_error) == '0))
		else $error("An rtr_error bit fell outside reset");

	quiet_in_reset: assert property (@(posedge clk)
		(!arst_n && $past(!arst_n)) |-> (!ejection_channel_0[VALID] &&
		!ejection_channel_8[VALID] && !injection_flow_ctrl_0 && !injection_flow_ctrl_8 &&
		rtr_error == '0))
		else $error("Mesh outputs active during reset");

endmodule

bind noc_mesh_3x3 noc_mesh_3x3_sva u_noc_mesh_3x3_sva (
	.clk(clk),
	.arst_n(arst_n),
	.ejection_channel_0(ejection_channel_0),
	.ejection_flow_ctrl_0(ejection_flow_ctrl_0),
	.ejection_channel_8(ejection_channel_8),
	.ejection_flow_ctrl_8(ejection_flow_ctrl_8),
	.injection_flow_ctrl_0(injection_flow_ctrl_0),
	.injection_flow_ctrl_8(injection_flow_ctrl_8),
	.rtr_error(rtr_error)
);

`default_nettype wire

// File: logic/noc_mesh_3x3.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module noc_mesh_3x3 (
	input wire logic clk,
	input wire logic arst_n,
	input wire noc_pkg::flit_t injection_channel_0,
	output logic injection_flow_ctrl_0,
	output noc_pkg::flit_t ejection_channel_0,
	input wire logic ejection_flow_ctrl_0,
	input wire noc_pkg::flit_t injection_channel_8,
	output logic injection_flow_ctrl_8,
	output noc_pkg::flit_t ejection_channel_8,
	input wire logic ejection_flow_ctrl_8,
	output wire [`NOC_NUM_ROUTERS-1:0] rtr_error
);

	localparam int DIM = `NOC_MESH_DIM;
	localparam int NR = `NOC_NUM_ROUTERS;
	localparam int NP = `NOC_NUM_PORTS;
	localparam int LOCAL = `NOC_PORT_LOCAL;
	localparam int XM = noc_pkg::PORT_X_MINUS;
	localparam int XP = noc_pkg::PORT_X_PLUS;
	localparam int YM = noc_pkg::PORT_Y_MINUS;
	localparam int YP = noc_pkg::PORT_Y_PLUS;

	// Per router port bundles. Router r sits at x = r % DIM and y = r / DIM.
	wire noc_pkg::flit_t [NP-1:0] channel_in [NR];
	wire noc_pkg::flit_t [NP-1:0] channel_out [NR];
	wire [NP-1:0] flow_ctrl_in [NR]; // Stop seen by the router's outputs.
	wire [NP-1:0] flow_ctrl_out [NR]; // Stop raised by the router's inputs.

	for (genvar y = 0; y < DIM; y++) begin : g_row
		for (genvar x = 0; x < DIM; x++) begin : g_col
			localparam int R = y * DIM + x;

			if (x > 0) begin : g_xm
				assign channel_in[R][XM] = channel_out[R-1][XP];
				assign flow_ctrl_in[R][XM] = flow_ctrl_out[R-1][XP];
			end else begin : g_xm_edge
				assign channel_in[R][XM] = '0;
				assign flow_ctrl_in[R][XM] = 1'b0;
			end

			if (x < DIM - 1) begin : g_xp
				assign channel_in[R][XP] = channel_out[R+1][XM];
				assign flow_ctrl_in[R][XP] = flow_ctrl_out[R+1][XM];
			end else begin : g_xp_edge
				assign channel_in[R][XP] = '0;
				assign flow_ctrl_in[R][XP] = 1'b0;
			end

			if (y > 0) begin : g_ym
				assign channel_in[R][YM] = channel_out[R-DIM][YP];
				assign flow_ctrl_in[R][YM] = flow_ctrl_out[R-DIM][YP];
			end else begin : g_ym_edge
				assign channel_in[R][YM] = '0;
				assign flow_ctrl_in[R][YM] = 1'b0;
			end

			if (y < DIM - 1) begin : g_yp
				assign channel_in[R][YP] = channel_out[R+DIM][YM];
				assign flow_ctrl_in[R][YP] = flow_ctrl_out[R+DIM][YM];
			end else begin : g_yp_edge
				assign channel_in[R][YP] = '0;
				assign flow_ctrl_in[R][YP] = 1'b0;
			end

			// Only the two corner routers have a traffic source and sink.
			if (R == 0) begin : g_local_first
				assign channel_in[R][LOCAL] = injection_channel_0;
				assign flow_ctrl_in[R][LOCAL] = ejection_flow_ctrl_0;
			end else if (R == NR - 1) begin : g_local_last
				assign channel_in[R][LOCAL] = injection_channel_8;
				assign flow_ctrl_in[R][LOCAL] = ejection_flow_ctrl_8;
			end else begin : g_local_tie
				assign channel_in[R][LOCAL] = '0;
				assign flow_ctrl_in[R][LOCAL] = 1'b0;
			end

			noc_router #(
				.ROUTER_X(x),
				.ROUTER_Y(y)
			) u_router (
				.clk(clk),
				.arst_n(arst_n),
				.channel_in(channel_in[R]),
				.flow_ctrl_out(flow_ctrl_out[R]),
				.channel_out(channel_out[R]),
				.flow_ctrl_in(flow_ctrl_in[R]),
				.error(rtr_error[R])
			);
		end
	end

	assign injection_flow_ctrl_0 = flow_ctrl_out[0][LOCAL];
	assign ejection_channel_0 = channel_out[0][LOCAL];
	assign injection_flow_ctrl_8 = flow_ctrl_out[NR-1][LOCAL];
	assign ejection_channel_8 = channel_out[NR-1][LOCAL];

endmodule

`default_nettype wire

// File: logic/noc_router.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module noc_router #(
	parameter int ROUTER_X = 0,
	parameter int ROUTER_Y = 0
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] channel_in,
	output wire [`NOC_NUM_PORTS-1:0] flow_ctrl_out,
	output wire noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] channel_out,
	input wire logic [`NOC_NUM_PORTS-1:0] flow_ctrl_in,
	output logic error
);

	localparam int NP = `NOC_NUM_PORTS;

	wire noc_pkg::flit_t [NP-1:0] in_flit;
	wire noc_pkg::port_sel_t [NP-1:0] in_request; // Indexed by input, bit per output.
	wire noc_pkg::port_sel_t [NP-1:0] out_grants; // Indexed by output, bit per input.
	wire [NP-1:0] in_error;
	noc_pkg::port_sel_t [NP-1:0] out_requests;
	logic [NP-1:0] in_grant;

	// Turn the request rows into one column per output.
	always_comb begin
		for (int o = 0; o < NP; o++) begin
			for (int i = 0; i < NP; i++) begin
				out_requests[o][i] = in_request[i][o];
			end
		end
	end

	// Gather the grants of each input.
	always_comb begin
		in_grant = '0;
		for (int o = 0; o < NP; o++) begin
			for (int i = 0; i < NP; i++) begin
				in_grant[i] = in_grant[i] | out_grants[o][i];
			end
		end
	end

	for (genvar p = 0; p < NP; p++) begin : g_port
		noc_input_buffer #(
			.ROUTER_X(ROUTER_X),
			.ROUTER_Y(ROUTER_Y)
		) u_input_buffer (
			.clk(clk),
			.arst_n(arst_n),
			.flit_in(channel_in[p]),
			.stop(flow_ctrl_out[p]),
			.flit(in_flit[p]),
			.request(in_request[p]),
			.grant(in_grant[p]),
			.error(in_error[p])
		);

		noc_output_port u_output_port (
			.clk(clk),
			.arst_n(arst_n),
			.requests(out_requests[p]),
			.flits_in(in_flit),
			.stop(flow_ctrl_in[p]),
			.grants(out_grants[p]),
			.flit_out(channel_out[p])
		);
	end

	assign error = |in_error;

endmodule

`default_nettype wire

// File: logic/noc_output_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module noc_output_port (
	input wire logic clk,
	input wire logic arst_n,
	input wire noc_pkg::port_sel_t requests,
	input wire noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] flits_in,
	input wire logic stop,
	output noc_pkg::port_sel_t grants,
	output noc_pkg::flit_t flit_out
);

	localparam int NUM_PORTS = `NOC_NUM_PORTS;
	localparam int SEL_W = $clog2(NUM_PORTS);

	logic out_valid_q;
	logic [`NOC_FLIT_WIDTH-2:0] data_q;
	logic [SEL_W-1:0] last_q;
	logic [SEL_W-1:0] win;
	logic can_load;
	logic leaving;

	assign leaving = out_valid_q && !stop;
	assign can_load = !out_valid_q || !stop; // Empty, or the current flit leaves now.

	// Round robin search starting just after the last winner.
	always_comb begin
		int idx;
		logic found;
		grants = '0;
		win = last_q;
		found = 1'b0;
		for (int i = 1; i <= NUM_PORTS; i++) begin
			idx = (int'(last_q) + i) % NUM_PORTS;
			if (can_load && !found && requests[idx]) begin
				found = 1'b1;
				grants[idx] = 1'b1;
				win = SEL_W'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid_q <= 1'b0;
			last_q <= SEL_W'(NUM_PORTS - 1); // Input 0 wins first.
		end else if (|grants) begin
			out_valid_q <= 1'b1;
			last_q <= win;
		end else if (leaving) begin
			out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (|grants)
			data_q <= flits_in[win][`NOC_FLIT_WIDTH-2:0];
	end

	// An idle channel carries all zeros.
	assign flit_out = out_valid_q ? {1'b1, data_q} : '0;

endmodule

`default_nettype wire

// File: logic/noc_input_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "noc_config.svh"

module noc_input_buffer #(
	parameter int ROUTER_X = 0,
	parameter int ROUTER_Y = 0
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire noc_pkg::flit_t flit_in,
	output logic stop,
	output noc_pkg::flit_t flit,
	output noc_pkg::port_sel_t request,
	input wire logic grant,
	output logic error
);

	localparam noc_pkg::coord_t OWN_X = noc_pkg::coord_t'(ROUTER_X);
	localparam noc_pkg::coord_t OWN_Y = noc_pkg::coord_t'(ROUTER_Y);
	localparam noc_pkg::addr_t OWN_ADDR = {OWN_X, OWN_Y};

	logic full_q;
	logic error_q;
	noc_pkg::flit_t flit_q;
	noc_pkg::coord_t dest_x;
	noc_pkg::coord_t dest_y;
	noc_pkg::addr_t dest_addr;
	logic off_mesh;
	noc_pkg::port_sel_t route;

	assign dest_x = noc_pkg::flit_dest_x(flit_q);
	assign dest_y = noc_pkg::flit_dest_y(flit_q);
	assign dest_addr = {dest_x, dest_y};
	assign off_mesh = (int'(dest_x) >= `NOC_MESH_DIM) || (int'(dest_y) >= `NOC_MESH_DIM);

	// XY routing. X is resolved completely before Y.
	always_comb begin
		route = '0;
		if (dest_addr == OWN_ADDR)
			route[`NOC_PORT_LOCAL] = 1'b1;
		else if (dest_x > OWN_X)
			route[noc_pkg::PORT_X_PLUS] = 1'b1;
		else if (dest_x < OWN_X)
			route[noc_pkg::PORT_X_MINUS] = 1'b1;
		else if (dest_y > OWN_Y)
			route[noc_pkg::PORT_Y_PLUS] = 1'b1;
		else
			route[noc_pkg::PORT_Y_MINUS] = 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			if (full_q && off_mesh)
				error_q <= 1'b1; // Sticky until reset.
			if (!full_q)
				full_q <= noc_pkg::flit_valid(flit_in);
			else if (grant || off_mesh)
				full_q <= 1'b0; // Off-mesh flits are dropped here.
		end
	end

	always_ff @(posedge clk) begin
		if (!full_q && noc_pkg::flit_valid(flit_in))
			flit_q <= flit_in;
	end

	assign stop = full_q;
	assign flit = flit_q;
	assign request = (full_q && !off_mesh) ? route : '0;
	assign error = error_q;

endmodule

`default_nettype wire

// File: logic/noc_pkg.sv
`default_nettype none
`include "noc_config.svh"

package noc_pkg;

	typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;
	typedef logic [2*`NOC_COORD_WIDTH-1:0] addr_t; // X in the upper half.
	typedef logic [`NOC_PAYLOAD_WIDTH-1:0] payload_t;
	typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;
	typedef logic [`NOC_NUM_PORTS-1:0] port_sel_t;

	// Neighbour port directions.
	localparam int PORT_X_MINUS = 0;
	localparam int PORT_X_PLUS = 1;
	localparam int PORT_Y_MINUS = 2;
	localparam int PORT_Y_PLUS = 3;

	localparam int VALID_BIT = `NOC_FLIT_WIDTH - 1;
	localparam int DEST_X_LSB = VALID_BIT - `NOC_COORD_WIDTH;
	localparam int DEST_Y_LSB = DEST_X_LSB - `NOC_COORD_WIDTH;

	function automatic logic flit_valid(flit_t f);
		return f[VALID_BIT];
	endfunction

	function automatic coord_t flit_dest_x(flit_t f);
		return f[DEST_X_LSB +: `NOC_COORD_WIDTH];
	endfunction

	function automatic coord_t flit_dest_y(flit_t f);
		return f[DEST_Y_LSB +: `NOC_COORD_WIDTH];
	endfunction

	function automatic payload_t flit_payload(flit_t f);
		return f[`NOC_PAYLOAD_WIDTH-1:0];
	endfunction

	function automatic flit_t make_flit(coord_t x, coord_t y, payload_t p);
		return {1'b1, x, y, p};
	endfunction

endpackage

`default_nettype wire

// File: logic/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Mesh geometry.
`define NOC_MESH_DIM 3
`define NOC_NUM_ROUTERS (`NOC_MESH_DIM * `NOC_MESH_DIM)

// Router ports. The last one is the local port.
`define NOC_NUM_PORTS 5
`define NOC_PORT_LOCAL 4

// Flit layout is valid, destination x, destination y, payload.
`define NOC_COORD_WIDTH 2
`define NOC_PAYLOAD_WIDTH 30
`define NOC_FLIT_WIDTH (1 + 2 * `NOC_COORD_WIDTH + `NOC_PAYLOAD_WIDTH)

`endif
